// File: rtl/rot_pkg.sv
`default_nettype none

package rot_pkg;

   localparam int XLEN = 64;

   typedef logic [XLEN-1:0]         dword_t;
   typedef logic [$clog2(XLEN)-1:0] shamt_t;
   typedef logic [31:0]             instr_t;

   // Names the data that shows through where the mask is zero
   typedef enum logic [1:0] {
      FILL_ZERO = 2'd0,
      FILL_SIGN = 2'd1,
      FILL_RS1  = 2'd2
   } fill_sel_t;

   // Primary opcodes
   localparam logic [5:0] OP_RLWIMI = 6'd20;
   localparam logic [5:0] OP_RLWINM = 6'd21;
   localparam logic [5:0] OP_RLWNM  = 6'd23;
   localparam logic [5:0] OP_X31    = 6'd31;

   // Extended opcodes under primary 31
   localparam logic [9:0] XO_SLW   = 10'd24;
   localparam logic [9:0] XO_SRW   = 10'd536;
   localparam logic [9:0] XO_SRAW  = 10'd792;
   localparam logic [9:0] XO_SRAWI = 10'd824;
   localparam logic [9:0] XO_SLD   = 10'd27;
   localparam logic [9:0] XO_SRD   = 10'd539;
   localparam logic [9:0] XO_SRAD  = 10'd794;

endpackage

`default_nettype wire

// File: rtl/rot_dec.sv
`timescale 1ns/1ns
`default_nettype none

module rot_dec
   import rot_pkg::*;
(
   input  logic      nclk,
   input  logic      rst_n,
   input  logic      ex1_act,
   input  instr_t    ex1_instr,
   output logic      ex2_act,
   output logic      ex2_use_rb_amt,
   output logic      ex2_use_rb_mask,
   output logic      ex2_sh_right,
   output logic      ex2_sh_word,
   output logic      ex2_chk_shov_wd,
   output logic      ex2_chk_shov_dw,
   output logic      ex2_zm_ins,
   output logic      ex2_sra,
   output shamt_t    ex2_sh_imm,
   output shamt_t    ex2_mb_imm,
   output shamt_t    ex2_me_imm,
   output fill_sel_t ex2_fill_sel
);

   logic [5:0] ex1_opcd;
   logic [9:0] ex1_xo;
   logic [4:0] ex1_sh5;
   logic [4:0] ex1_mb5;
   logic [4:0] ex1_me5;

   logic      ex1_use_rb_amt;
   logic      ex1_use_rb_mask;
   logic      ex1_sh_right;
   logic      ex1_sh_word;
   logic      ex1_chk_shov_wd;
   logic      ex1_chk_shov_dw;
   logic      ex1_zm_ins;
   logic      ex1_sra;
   shamt_t    ex1_sh_imm;
   shamt_t    ex1_mb_imm;
   shamt_t    ex1_me_imm;
   fill_sel_t ex1_fill_sel;

   // Power bit i sits at index 31-i of the instruction word
   assign ex1_opcd = ex1_instr[31:26];
   assign ex1_sh5  = ex1_instr[15:11];
   assign ex1_mb5  = ex1_instr[10:6];
   assign ex1_me5  = ex1_instr[5:1];
   assign ex1_xo   = ex1_instr[10:1];

   always_comb begin
      ex1_use_rb_amt  = 1'b0;
      ex1_use_rb_mask = 1'b0;
      ex1_sh_right    = 1'b0;
      ex1_sh_word     = 1'b0;
      ex1_chk_shov_wd = 1'b0;
      ex1_chk_shov_dw = 1'b0;
      ex1_zm_ins      = 1'b0;
      ex1_sra         = 1'b0;
      ex1_sh_imm      = {1'b0, ex1_sh5};
      // Word forms place MB and ME in the low word
      ex1_mb_imm      = {1'b1, ex1_mb5};
      ex1_me_imm      = {1'b1, ex1_me5};
      ex1_fill_sel    = FILL_ZERO;

      case (ex1_opcd)
         OP_RLWIMI: begin
            ex1_sh_word  = 1'b1;
            ex1_fill_sel = FILL_RS1;
         end
         OP_RLWINM: begin
            ex1_sh_word = 1'b1;
         end
         OP_RLWNM: begin
            ex1_sh_word    = 1'b1;
            ex1_use_rb_amt = 1'b1;
         end
         OP_X31: begin
            ex1_sh_word     = (ex1_xo == XO_SLW) || (ex1_xo == XO_SRW) ||
                              (ex1_xo == XO_SRAW) || (ex1_xo == XO_SRAWI);
            ex1_sh_right    = (ex1_xo != XO_SLW) && (ex1_xo != XO_SLD);
            ex1_use_rb_amt  = (ex1_xo != XO_SRAWI);
            ex1_use_rb_mask = (ex1_xo != XO_SRAWI);
            ex1_chk_shov_wd = ex1_sh_word && (ex1_xo != XO_SRAWI);
            ex1_chk_shov_dw = !ex1_sh_word;
            ex1_sra         = (ex1_xo == XO_SRAW) || (ex1_xo == XO_SRAWI) ||
                              (ex1_xo == XO_SRAD);
            // Shift masks keep one end fixed and take the other end from the amount
            ex1_mb_imm      = {ex1_sh_word, 5'd0};
            ex1_me_imm      = 6'd63;
            if (ex1_xo == XO_SRAWI) begin
               ex1_mb_imm = {1'b1, ex1_sh5};
            end
            if (ex1_sra) begin
               ex1_fill_sel = FILL_SIGN;
            end
            case (ex1_xo)
               XO_SLW, XO_SRW, XO_SRAW, XO_SRAWI, XO_SLD, XO_SRD, XO_SRAD: begin
                  ex1_zm_ins = 1'b0;
               end
               default: begin
                  ex1_zm_ins   = 1'b1;
                  ex1_sra      = 1'b0;
                  ex1_fill_sel = FILL_ZERO;
               end
            endcase
         end
         default: begin
            ex1_zm_ins = 1'b1;
         end
      endcase
   end

   always_ff @(posedge nclk or negedge rst_n) begin
      if (!rst_n) begin
         ex2_act <= 1'b0;
      end else begin
         ex2_act <= ex1_act;
      end
   end

   always_ff @(posedge nclk or negedge rst_n) begin
      if (!rst_n) begin
         ex2_use_rb_amt  <= 1'b0;
         ex2_use_rb_mask <= 1'b0;
         ex2_sh_right    <= 1'b0;
         ex2_sh_word     <= 1'b0;
         ex2_chk_shov_wd <= 1'b0;
         ex2_chk_shov_dw <= 1'b0;
         ex2_zm_ins      <= 1'b0;
         ex2_sra         <= 1'b0;
         ex2_sh_imm      <= '0;
         ex2_mb_imm      <= '0;
         ex2_me_imm      <= '0;
         ex2_fill_sel    <= FILL_ZERO;
      end else if (ex1_act) begin
         ex2_use_rb_amt  <= ex1_use_rb_amt;
         ex2_use_rb_mask <= ex1_use_rb_mask;
         ex2_sh_right    <= ex1_sh_right;
         ex2_sh_word     <= ex1_sh_word;
         ex2_chk_shov_wd <= ex1_chk_shov_wd;
         ex2_chk_shov_dw <= ex1_chk_shov_dw;
         ex2_zm_ins      <= ex1_zm_ins;
         ex2_sra         <= ex1_sra;
         ex2_sh_imm      <= ex1_sh_imm;
         ex2_mb_imm      <= ex1_mb_imm;
         ex2_me_imm      <= ex1_me_imm;
         ex2_fill_sel    <= ex1_fill_sel;
      end
   end

endmodule

`default_nettype wire

// File: rtl/rot_mask_gen.sv
`timescale 1ns/1ns
`default_nettype none

module rot_mask_gen
   import rot_pkg::*;
(
   input  dword_t ex2_rs1,
   input  shamt_t ex2_sh_imm,
   input  shamt_t ex2_mb_imm,
   input  shamt_t ex2_me_imm,
   input  logic   ex2_use_rb_amt,
   input  logic   ex2_use_rb_mask,
   input  logic   ex2_sh_right,
   input  logic   ex2_sh_word,
   input  logic   ex2_chk_shov_wd,
   input  logic   ex2_chk_shov_dw,
   input  logic   ex2_zm_ins,
   output shamt_t ex2_sh_amt,
   output dword_t ex2_mask
);

   shamt_t ex2_rb_amt;
   shamt_t ex2_mb_rb;
   shamt_t ex2_me_rb;
   shamt_t ex2_mb;
   shamt_t ex2_me;
   logic   ex2_zm;
   logic   ex2_mb_gt_me;
   dword_t ex2_from_mb;
   dword_t ex2_to_me;

   // Word forms take only the low five bits of RB as the amount
   assign ex2_rb_amt = ex2_rs1[5:0] & {~ex2_sh_word, 5'h1f};
   assign ex2_sh_amt = ex2_use_rb_amt ? ex2_rb_amt : ex2_sh_imm;

   // Right shifts start the mask at the amount, left shifts end it at 63 minus the amount
   assign ex2_mb_rb = ex2_rb_amt | {ex2_sh_word, 5'd0};
   assign ex2_me_rb = ~ex2_rb_amt;

   assign ex2_mb = (ex2_use_rb_mask && ex2_sh_right) ? ex2_mb_rb : ex2_mb_imm;
   assign ex2_me = (ex2_use_rb_mask && !ex2_sh_right) ? ex2_me_rb : ex2_me_imm;

   // RB bit 58 overflows a word shift and bit 57 a doubleword shift
   assign ex2_zm = ex2_zm_ins ||
                   (ex2_chk_shov_wd && ex2_rs1[5]) ||
                   (ex2_chk_shov_dw && ex2_rs1[6]);

   // Power bits at or after mb, and at or before me
   assign ex2_from_mb  = {XLEN{1'b1}} >> ex2_mb;
   assign ex2_to_me    = {XLEN{1'b1}} << ex2_me_rb_dist(ex2_me);
   assign ex2_mb_gt_me = (ex2_mb > ex2_me);

   always_comb begin
      if (ex2_zm) begin
         ex2_mask = '0;
      end else if (ex2_mb_gt_me) begin
         ex2_mask = ex2_from_mb | ex2_to_me;
      end else begin
         ex2_mask = ex2_from_mb & ex2_to_me;
      end
   end

   // Distance of the mask end from the least significant bit
   function automatic shamt_t ex2_me_rb_dist(input shamt_t me);
      return ~me;
   endfunction

endmodule

`default_nettype wire

// File: rtl/rot_rol64.sv
`timescale 1ns/1ns
`default_nettype none

module rot_rol64
   import rot_pkg::*;
(
   input  dword_t ex2_rs0,
   input  shamt_t ex2_sh_amt,
   input  logic   ex2_sh_word,
   input  logic   ex2_sh_right,
   output dword_t ex2_rotate
);

   dword_t            ex2_data;
   shamt_t            ex2_rol_amt;
   logic [2*XLEN-1:0] ex2_dbl;

   // Word forms see the low word in both halves, so any rotate stays a word rotate
   assign ex2_data = ex2_sh_word ? {ex2_rs0[31:0], ex2_rs0[31:0]} : ex2_rs0;

   // A right rotate by n is a left rotate by 64 minus n
   assign ex2_rol_amt = ex2_sh_right ? shamt_t'(6'd0 - ex2_sh_amt) : ex2_sh_amt;

   assign ex2_dbl    = {ex2_data, ex2_data} << ex2_rol_amt;
   assign ex2_rotate = ex2_dbl[2*XLEN-1:XLEN];

endmodule

`default_nettype wire

// File: rtl/rot_merge.sv
`timescale 1ns/1ns
`default_nettype none

module rot_merge
   import rot_pkg::*;
(
   input  logic      nclk,
   input  logic      rst_n,
   input  logic      ex2_act,
   input  logic      ex2_sh_word,
   input  logic      ex2_sra,
   input  dword_t    ex2_rotate,
   input  dword_t    ex2_mask,
   input  dword_t    ex2_rs0,
   input  dword_t    ex2_rs1,
   input  fill_sel_t ex2_fill_sel,
   output logic      ex3_valid,
   output logic      ex3_xer_ca,
   output dword_t    ex3_rt
);

   logic   ex2_sign;
   dword_t ex2_fill;
   dword_t ex2_result;
   dword_t ex2_dropped;

   logic   ex3_sra_se;
   logic   ex3_sh_word;
   dword_t ex3_dropped;
   logic   ex3_or_lo;
   logic   ex3_or_hi;

   assign ex2_sign = ex2_sh_word ? ex2_rs0[31] : ex2_rs0[63];

   always_comb begin
      case (ex2_fill_sel)
         FILL_SIGN: ex2_fill = {XLEN{ex2_sign}};
         FILL_RS1:  ex2_fill = ex2_rs1;
         default:   ex2_fill = '0;
      endcase
   end

   assign ex2_result  = (ex2_rotate & ex2_mask) | (ex2_fill & ~ex2_mask);
   // Bits shifted out by an algebraic shift
   assign ex2_dropped = ex2_rotate & ~ex2_mask;

   always_ff @(posedge nclk or negedge rst_n) begin
      if (!rst_n) begin
         ex3_valid <= 1'b0;
      end else begin
         ex3_valid <= ex2_act;
      end
   end

   always_ff @(posedge nclk or negedge rst_n) begin
      if (!rst_n) begin
         ex3_rt     <= '0;
         ex3_sra_se <= 1'b0;
      end else if (ex2_act) begin
         ex3_rt     <= ex2_result;
         ex3_sra_se <= ex2_sra & ex2_sign;
      end
   end

   always_ff @(posedge nclk) begin
      if (ex2_act) begin
         ex3_dropped <= ex2_dropped;
         ex3_sh_word <= ex2_sh_word;
      end
   end

   assign ex3_or_lo = |ex3_dropped[31:0];
   assign ex3_or_hi = |ex3_dropped[63:32];

   // Word shifts only look at the low word for the carry
   assign ex3_xer_ca = ex3_sra_se & (ex3_or_lo | (ex3_or_hi & ~ex3_sh_word));

endmodule

`default_nettype wire

// File: rtl/rot_top.sv
`timescale 1ns/1ns
`default_nettype none

module rot_top
   import rot_pkg::*;
(
   input  logic   nclk,
   input  logic   rst_n,
   input  logic   ex1_act,
   input  instr_t ex1_instr,
   input  dword_t ex2_rs0,
   input  dword_t ex2_rs1,
   output logic   ex3_valid,
   output logic   ex3_xer_ca,
   output dword_t ex3_rt
);

   logic      ex2_act;
   logic      ex2_use_rb_amt;
   logic      ex2_use_rb_mask;
   logic      ex2_sh_right;
   logic      ex2_sh_word;
   logic      ex2_chk_shov_wd;
   logic      ex2_chk_shov_dw;
   logic      ex2_zm_ins;
   logic      ex2_sra;
   shamt_t    ex2_sh_imm;
   shamt_t    ex2_mb_imm;
   shamt_t    ex2_me_imm;
   fill_sel_t ex2_fill_sel;

   shamt_t    ex2_sh_amt;
   dword_t    ex2_mask;
   dword_t    ex2_rotate;

   rot_dec dec (
      .nclk            (nclk),
      .rst_n           (rst_n),
      .ex1_act         (ex1_act),
      .ex1_instr       (ex1_instr),
      .ex2_act         (ex2_act),
      .ex2_use_rb_amt  (ex2_use_rb_amt),
      .ex2_use_rb_mask (ex2_use_rb_mask),
      .ex2_sh_right    (ex2_sh_right),
      .ex2_sh_word     (ex2_sh_word),
      .ex2_chk_shov_wd (ex2_chk_shov_wd),
      .ex2_chk_shov_dw (ex2_chk_shov_dw),
      .ex2_zm_ins      (ex2_zm_ins),
      .ex2_sra         (ex2_sra),
      .ex2_sh_imm      (ex2_sh_imm),
      .ex2_mb_imm      (ex2_mb_imm),
      .ex2_me_imm      (ex2_me_imm),
      .ex2_fill_sel    (ex2_fill_sel)
   );

   rot_mask_gen msk (
      .ex2_rs1         (ex2_rs1),
      .ex2_sh_imm      (ex2_sh_imm),
      .ex2_mb_imm      (ex2_mb_imm),
      .ex2_me_imm      (ex2_me_imm),
      .ex2_use_rb_amt  (ex2_use_rb_amt),
      .ex2_use_rb_mask (ex2_use_rb_mask),
      .ex2_sh_right    (ex2_sh_right),
      .ex2_sh_word     (ex2_sh_word),
      .ex2_chk_shov_wd (ex2_chk_shov_wd),
      .ex2_chk_shov_dw (ex2_chk_shov_dw),
      .ex2_zm_ins      (ex2_zm_ins),
      .ex2_sh_amt      (ex2_sh_amt),
      .ex2_mask        (ex2_mask)
   );

   rot_rol64 rol64 (
      .ex2_rs0      (ex2_rs0),
      .ex2_sh_amt   (ex2_sh_amt),
      .ex2_sh_word  (ex2_sh_word),
      .ex2_sh_right (ex2_sh_right),
      .ex2_rotate   (ex2_rotate)
   );

   rot_merge mrg (
      .nclk         (nclk),
      .rst_n        (rst_n),
      .ex2_act      (ex2_act),
      .ex2_sh_word  (ex2_sh_word),
      .ex2_sra      (ex2_sra),
      .ex2_rotate   (ex2_rotate),
      .ex2_mask     (ex2_mask),
      .ex2_rs0      (ex2_rs0),
      .ex2_rs1      (ex2_rs1),
      .ex2_fill_sel (ex2_fill_sel),
      .ex3_valid    (ex3_valid),
      .ex3_xer_ca   (ex3_xer_ca),
      .ex3_rt       (ex3_rt)
   );

endmodule

`default_nettype wire

// File: dv/rot_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module rot_asserts
   import rot_pkg::*;
(
   input logic   nclk,
   input logic   rst_n,
   input logic   ex1_act,
   input instr_t ex1_instr,
   input dword_t ex2_rs0,
   input dword_t ex2_rs1,
   input logic   ex3_valid,
   input logic   ex3_xer_ca,
   input dword_t ex3_rt
);

   logic        failed = 1'b0;
   logic        act_q1;
   logic        act_q2;
   instr_t      ins_q1;
   instr_t      ins_q2;
   dword_t      rs0_q1;
   dword_t      rs1_q1;
   logic [64:0] exp_all;
   dword_t      exp_rt;
   logic        exp_ca;

   // Power mask from bit b to bit e, wrapping when b is past e
   function automatic dword_t pmask(input int b, input int e);
      dword_t m;
      for (int i = 0; i < 64; i++) begin
         m[63-i] = (b <= e) ? (i >= b && i <= e) : (i >= b || i <= e);
      end
      return m;
   endfunction

   function automatic dword_t rotl32(input logic [31:0] w, input int n);
      dword_t x;
      x = {w, w};
      return (x << n) | (x >> (64 - n));
   endfunction

   function automatic string kind_name(input instr_t ins);
      case (ins[31:26])
         OP_RLWINM, OP_RLWNM: return "rotate_mask";
         OP_RLWIMI:           return "insert";
         OP_X31: begin
            case (ins[10:1])
               XO_SLW, XO_SRW, XO_SLD, XO_SRD: return "logical_shift";
               XO_SRAW, XO_SRAWI, XO_SRAD:     return "algebraic_shift";
               default:                        return "unsupported";
            endcase
         end
         default: return "unsupported";
      endcase
   endfunction

   // Carry in bit 64, result below it
   function automatic logic [64:0] model(input instr_t ins, input dword_t rs, input dword_t rb);
      logic signed [63:0] w;
      dword_t             m;
      dword_t             res;
      logic               ca;
      int                 n;
      res = '0;
      ca  = 1'b0;
      m   = pmask(int'(ins[10:6]) + 32, int'(ins[5:1]) + 32);
      case (ins[31:26])
         OP_RLWIMI: res = (rotl32(rs[31:0], ins[15:11]) & m) | (rb & ~m);
         OP_RLWINM: res = rotl32(rs[31:0], ins[15:11]) & m;
         OP_RLWNM:  res = rotl32(rs[31:0], rb[4:0]) & m;
         OP_X31: begin
            case (ins[10:1])
               XO_SLW: res = rb[5] ? 64'd0 : {32'd0, rs[31:0] << rb[4:0]};
               XO_SRW: res = rb[5] ? 64'd0 : {32'd0, rs[31:0] >> rb[4:0]};
               XO_SLD: res = rb[6] ? 64'd0 : rs << rb[5:0];
               XO_SRD: res = rb[6] ? 64'd0 : rs >> rb[5:0];
               XO_SRAW, XO_SRAWI: begin
                  n   = (ins[10:1] == XO_SRAWI) ? int'(ins[15:11]) :
                        (rb[5] ? 32 : int'(rb[4:0]));
                  w   = {{32{rs[31]}}, rs[31:0]};
                  res = w >>> n;
                  ca  = rs[31] && ((rs[31:0] & ~(32'hffff_ffff << n)) != 32'd0);
               end
               XO_SRAD: begin
                  n   = rb[6] ? 64 : int'(rb[5:0]);
                  w   = rs;
                  res = w >>> n;
                  ca  = rs[63] && ((rs & ~({64{1'b1}} << n)) != 64'd0);
               end
               default: res = '0;
            endcase
         end
         default: res = '0;
      endcase
      return {ca, res};
   endfunction

   always_ff @(posedge nclk or negedge rst_n) begin
      if (!rst_n) begin
         act_q1 <= 1'b0;
         act_q2 <= 1'b0;
      end else begin
         act_q1 <= ex1_act;
         act_q2 <= act_q1;
      end
   end

   // The instruction two cycles back meets the operands one cycle back
   always_ff @(posedge nclk) begin
      ins_q1 <= ex1_instr;
      ins_q2 <= ins_q1;
      rs0_q1 <= ex2_rs0;
      rs1_q1 <= ex2_rs1;
   end

   assign exp_all = model(ins_q2, rs0_q1, rs1_q1);
   assign exp_rt  = exp_all[63:0];
   assign exp_ca  = exp_all[64];

   a_reset: assert property (@(posedge nclk) $rose(rst_n) |-> !ex3_valid && ex3_rt == '0)
      else begin
         $error("ex3_valid or ex3_rt was not cleared by reset");
         failed = 1'b1;
      end

   a_latency: assert property (@(posedge nclk) disable iff (!rst_n) ex3_valid == act_q2)
      else begin
         $error("ex3_valid did not follow ex1_act by exactly two cycles");
         failed = 1'b1;
      end

   a_hold: assert property (@(posedge nclk) disable iff (!rst_n) !ex3_valid |-> $stable(ex3_rt))
      else begin
         $error("ex3_rt changed while ex3_valid was low");
         failed = 1'b1;
      end

   a_result: assert property (@(posedge nclk) disable iff (!rst_n) ex3_valid |-> ex3_rt == exp_rt)
      else begin
         $error("MISMATCH %s expected %h actual %h", kind_name($sampled(ins_q2)),
                $sampled(exp_rt), $sampled(ex3_rt));
         failed = 1'b1;
      end

   a_carry: assert property (@(posedge nclk) disable iff (!rst_n)
                             ex3_valid |-> ex3_xer_ca == exp_ca)
      else begin
         $error("MISMATCH %s_carry expected %b actual %b", kind_name($sampled(ins_q2)),
                $sampled(exp_ca), $sampled(ex3_xer_ca));
         failed = 1'b1;
      end

endmodule

`default_nettype wire

// File: dv/rot_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rot_tb
   import rot_pkg::*;
();

   localparam int GROUPS     = 6;
   localparam int PER_GROUP  = 40;
   localparam int MAX_CYCLES = 400;

   logic   nclk;
   logic   rst_n;
   logic   ex1_act;
   instr_t ex1_instr;
   dword_t ex2_rs0;
   dword_t ex2_rs1;
   logic   ex3_valid;
   logic   ex3_xer_ca;
   dword_t ex3_rt;

   dword_t nxt_rs0;
   dword_t nxt_rs1;
   int     cycles = 0;

   rot_top dut0 (
      .nclk       (nclk),
      .rst_n      (rst_n),
      .ex1_act    (ex1_act),
      .ex1_instr  (ex1_instr),
      .ex2_rs0    (ex2_rs0),
      .ex2_rs1    (ex2_rs1),
      .ex3_valid  (ex3_valid),
      .ex3_xer_ca (ex3_xer_ca),
      .ex3_rt     (ex3_rt)
   );

   bind rot_top rot_asserts chk (.*);

   initial begin
      nclk = 1'b0;
      forever #4 nclk = ~nclk;
   end

   // A new instruction enters ex1 while the previous one's operands enter ex2
   task automatic step(input logic act, input instr_t ins, input dword_t rs, input dword_t rb);
      @(posedge nclk);
      #1;
      ex1_act   = act;
      ex1_instr = ins;
      ex2_rs0   = nxt_rs0;
      ex2_rs1   = nxt_rs1;
      nxt_rs0   = rs;
      nxt_rs1   = rb;
   endtask

   function automatic instr_t pick_instr(input int grp);
      instr_t ins;
      ins = $urandom;
      case (grp)
         0: ins[31:26] = ($urandom_range(1) == 0) ? OP_RLWINM : OP_RLWNM;
         1: ins[31:26] = OP_RLWIMI;
         2: begin
            ins[31:26] = OP_X31;
            case ($urandom_range(3))
               0:       ins[10:1] = XO_SLW;
               1:       ins[10:1] = XO_SRW;
               2:       ins[10:1] = XO_SLD;
               default: ins[10:1] = XO_SRD;
            endcase
         end
         3: begin
            ins[31:26] = OP_X31;
            case ($urandom_range(2))
               0:       ins[10:1] = XO_SRAW;
               1:       ins[10:1] = XO_SRAWI;
               default: ins[10:1] = XO_SRAD;
            endcase
         end
         default: begin
            // Extended opcodes 64 to 95 are outside the kept set
            if (ins[31:26] == OP_X31) begin
               ins[10:6] = 5'd2;
            end else if (ins[31:26] inside {OP_RLWIMI, OP_RLWINM, OP_RLWNM}) begin
               ins[31:26] = 6'd0;
            end
         end
      endcase
      return ins;
   endfunction

   always @(posedge nclk) begin
      cycles <= cycles + 1;
      if (dut0.chk.failed) begin
         $display("SIMULATION FAILED");
         $fatal(1, "stopping at the first failed check");
      end else if (cycles >= MAX_CYCLES) begin
         $display("SIMULATION FAILED");
         $fatal(1, "timeout after %0d cycles", cycles);
      end
   end

   initial begin
      void'($urandom(32'h65f9_eced));
      rst_n     = 1'b0;
      ex1_act   = 1'b0;
      ex1_instr = '0;
      ex2_rs0   = '0;
      ex2_rs1   = '0;
      nxt_rs0   = '0;
      nxt_rs1   = '0;
      repeat (2) @(posedge nclk);
      #1;
      rst_n = 1'b1;

      // The last group mixes all kinds back to back
      for (int g = 0; g < GROUPS; g++) begin
         for (int i = 0; i < PER_GROUP; i++) begin
            if ($urandom_range(7) == 0) begin
               step(1'b0, $urandom, {$urandom, $urandom}, {$urandom, $urandom});
            end
            step(1'b1, pick_instr((g == 5) ? $urandom_range(4) : g),
                 {$urandom, $urandom}, {$urandom, $urandom});
         end
      end
      repeat (4) step(1'b0, '0, '0, '0);
      @(posedge nclk);

      if (dut0.chk.failed) begin
         $display("SIMULATION FAILED");
         $fatal(1, "a check failed during the drain");
      end else begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: build.f
rtl/rot_pkg.sv
rtl/rot_dec.sv
rtl/rot_mask_gen.sv
rtl/rot_rol64.sv
rtl/rot_merge.sv
rtl/rot_top.sv
dv/rot_asserts.sv
dv/rot_tb.sv

// File: Bender.yml
package:
  name: rot_unit

sources:
  - rtl/rot_pkg.sv
  - rtl/rot_dec.sv
  - rtl/rot_mask_gen.sv
  - rtl/rot_rol64.sv
  - rtl/rot_merge.sv
  - rtl/rot_top.sv
  - target: simulation
    files:
      - dv/rot_asserts.sv
      - dv/rot_tb.sv
